/* buttonSync.sv */
// Push-button synchronizer with rising-edge detect, one instance per button in the pet top level
`timescale 1ns/100ps
`default_nettype none

`include "pet_defs.svh"

module buttonSync (
	input  logic clk,
	input  logic rst,
	input  logic btn, // Raw level from the board
	output logic evt  // One-cycle pulse per press
);

	logic [`SYNC_STAGES-1:0] syncQ; // syncQ[0] samples the pin
	logic                    lastQ; // Newest synchronized sample, one cycle old

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			syncQ <= '0;
			lastQ <= 1'b0;
			evt   <= 1'b0;
		end else begin
			syncQ <= {syncQ[`SYNC_STAGES-2:0], btn};
			lastQ <= syncQ[`SYNC_STAGES-1];

			// Pulse on a 0 to 1 transition of the synchronized level.
			// A held button keeps lastQ high, so no repeat events
			evt <= syncQ[`SYNC_STAGES-1] & ~lastQ;
		end
	end

endmodule

`default_nettype wire

/* moodFsm.sv */
// Mood state machine of the pet, picks the registered mood from the meters and button events
`timescale 1ns/100ps
`default_nettype none

`include "pet_defs.svh"

module moodFsm import petPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        sleepEvt, // One-cycle sleep press
	input  logic        wakeEvt,  // One-cycle wake press
	input  meterLevel_t energy,
	input  meterLevel_t hunger,
	output moodState_t  mood
);

	localparam meterLevel_t FULL  = meterLevel_t'(`METER_MAX);
	localparam meterLevel_t LOW   = meterLevel_t'(`METER_LOW);
	localparam meterLevel_t EMPTY = meterLevel_t'(0);

	buttonEvt_t pending;   // Event seen this cycle
	moodState_t awakeMood; // Classify result for an awake pet
	moodState_t nextMood;
	logic       starved;   // A meter has run dry

	// Mood of an awake pet, first matching rule wins
	function automatic moodState_t classify(
		input meterLevel_t e,
		input meterLevel_t h
	);
		if (e == FULL && h == FULL) begin
			return IDLE;
		end else if (e <= LOW && h <= LOW) begin
			return SAD;
		end else if (e <= LOW) begin
			return TIRED;
		end else if (h <= LOW) begin
			return HUNGRY;
		end else begin
			return NEUTRAL;
		end
	endfunction

	// Reduce the two event lines to one pending event.
	// Wake is checked first when both arrive together
	always_comb begin
		if (wakeEvt) begin
			pending = EVT_WAKE;
		end else if (sleepEvt) begin
			pending = EVT_SLEEP;
		end else begin
			pending = EVT_NONE;
		end
	end

	assign awakeMood = classify(energy, hunger);
	assign starved   = (energy == EMPTY) || (hunger == EMPTY);

	// Next mood in priority order
	always_comb begin
		if (mood == DEATH) begin
			nextMood = DEATH; // Only reset leaves DEATH
		end else if (starved) begin
			nextMood = DEATH;
		end else if (mood == SLEEP) begin
			// Woken by a press, or wakes by itself once rested
			if (pending == EVT_WAKE || energy == FULL) begin
				nextMood = awakeMood;
			end else begin
				nextMood = SLEEP;
			end
		end else begin
			// Awake, a fully rested pet ignores a sleep press
			if (pending == EVT_SLEEP && energy < FULL) begin
				nextMood = SLEEP;
			end else begin
				nextMood = awakeMood;
			end
		end
	end

	// Mood register
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mood <= IDLE;
		end else begin
			mood <= nextMood;
		end
	end

endmodule

`default_nettype wire

/* petChecker.sv */
// Concurrent assertions on the pet mood and meters, bound into petTop by the testbench
`timescale 1ns/100ps
`default_nettype none

`include "pet_defs.svh"

module petChecker import petPkg::*; (
	input logic        clk,
	input logic        rst,
	input moodState_t  mood,
	input meterLevel_t energy,
	input meterLevel_t hunger
);

	localparam meterLevel_t FULL = meterLevel_t'(`METER_MAX);

	// DEATH is left only through reset
	deathHolds: assert property (@(posedge clk) disable iff (rst)
		mood == DEATH |=> mood == DEATH)
		else $error("mood left DEATH without a reset");

	metersInRange: assert property (@(posedge clk) disable iff (rst)
		energy <= FULL && hunger <= FULL)
		else $error("meter above its full level");

	// Meters move one level at a time
	energyStep: assert property (@(posedge clk) disable iff (rst)
		energy == $past(energy) || energy == $past(energy) + 3'd1 ||
		energy + 3'd1 == $past(energy))
		else $error("energy changed by more than one level");

	hungerStep: assert property (@(posedge clk) disable iff (rst)
		hunger == $past(hunger) || hunger == $past(hunger) + 3'd1 ||
		hunger + 3'd1 == $past(hunger))
		else $error("hunger changed by more than one level");

	resetValues: assert property (@(posedge clk)
		$fell(rst) |-> mood == IDLE && energy == FULL && hunger == FULL)
		else $error("wrong mood or meters after reset");

endmodule

`default_nettype wire

/* petPkg.sv */
// Shared types for the virtual-pet core, imported by the RTL modules and the testbench
`default_nettype none

package petPkg;

	// Meter level, 0 (empty) to METER_MAX (full)
	typedef logic [2:0] meterLevel_t;

	// Pet mood as reported at the top level
	typedef enum logic [2:0] {
		IDLE    = 3'd0, // Both meters full
		SLEEP   = 3'd1, // Resting, energy recovers
		NEUTRAL = 3'd2,
		TIRED   = 3'd4, // Energy low
		DEATH   = 3'd5, // Held until reset
		HUNGRY  = 3'd6, // Hunger low
		SAD     = 3'd7  // Both meters low
	} moodState_t;

	// Button event labels
	typedef enum logic [1:0] {
		EVT_NONE  = 2'd0,
		EVT_SLEEP = 2'd1,
		EVT_WAKE  = 2'd2,
		EVT_FEED  = 2'd3
	} buttonEvt_t;

endpackage

`default_nettype wire

/* petTb.sv */
// Testbench for petTop, directed and random button presses checked every cycle against a model
`timescale 1ns/100ps
`default_nettype none

`include "pet_defs.svh"

module petTb import petPkg::*; ();

	localparam int unsigned SEED = 32'h84cf34f2;
	localparam int ACTIONS = 400;
	localparam int DIRECTED_CYCLES = 4 * 400;         // Four directed tests, each well under this
	localparam int RANDOM_CYCLES = ACTIONS * (2 + 60 + 4 + 1); // Press, longest gap, reset
	localparam int MAX_CYCLES = 2 * (DIRECTED_CYCLES + RANDOM_CYCLES);
	localparam meterLevel_t FULL = meterLevel_t'(`METER_MAX);
	localparam meterLevel_t LOW = meterLevel_t'(`METER_LOW);

	logic clk, rst, sleepBtn, wakeBtn, feedBtn;
	moodState_t mood;
	meterLevel_t energy, hunger;

	// Reference model state
	logic [2:0] hSleep, hWake, hFeed; // Sampled button history, bit 0 newest
	logic mSleepEvt, mWakeEvt, mFeedEvt, mETick, mHTick;
	int eCnt, hCnt;
	meterLevel_t mEnergy, mHunger;
	moodState_t mMood;

	int errors = 0, checks = 0, tests = 0, testStartErrors = 0, cycles = 0;
	int unsigned r;
	int gap, len;
	buttonEvt_t act;
	meterLevel_t deadEnergy, deadHunger;

	petTop dut (.clk(clk), .rst(rst), .sleepBtn(sleepBtn), .wakeBtn(wakeBtn), .feedBtn(feedBtn),
		.mood(mood), .energy(energy), .hunger(hunger));

	bind petTop petChecker chk (.clk(clk), .rst(rst), .mood(mood),
		.energy(energy), .hunger(hunger));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Awake mood from the meters, first match wins
	function automatic moodState_t classifyAwake(meterLevel_t e, meterLevel_t h);
		logic eLow, hLow;
		eLow = (e <= LOW);
		hLow = (h <= LOW);
		if (e == FULL && h == FULL) return IDLE;
		if (eLow && hLow) return SAD;
		if (eLow) return TIRED;
		if (hLow) return HUNGRY;
		return NEUTRAL;
	endfunction

	function automatic moodState_t predictMood(moodState_t m, meterLevel_t e, meterLevel_t h,
		logic slp, logic wk);
		if (m == DEATH || e == 3'd0 || h == 3'd0) return DEATH;
		if (m == SLEEP) return (wk || e == FULL) ? classifyAwake(e, h) : SLEEP;
		if (slp && !wk && e < FULL) return SLEEP; // Wake wins if both arrive
		return classifyAwake(e, h);
	endfunction

	task automatic stepModel();
		meterLevel_t nE, nH;
		moodState_t nM;
		nE = mEnergy;
		nH = mHunger;
		if (mMood != DEATH) begin // Meters freeze once dead
			if (mETick && mMood == SLEEP && mEnergy < FULL) nE = mEnergy + 3'd1;
			else if (mETick && mEnergy > 3'd0) nE = mEnergy - 3'd1;
			if (mFeedEvt) nH = (mHunger < FULL) ? mHunger + 3'd1 : mHunger;
			else if (mHTick && mHunger > 3'd0) nH = mHunger - 3'd1;
		end
		nM = predictMood(mMood, mEnergy, mHunger, mSleepEvt, mWakeEvt);
		mSleepEvt = hSleep[1] & ~hSleep[2]; // Press seen two edges ago, released before that
		mWakeEvt = hWake[1] & ~hWake[2];
		mFeedEvt = hFeed[1] & ~hFeed[2];
		hSleep = {hSleep[1:0], sleepBtn};
		hWake = {hWake[1:0], wakeBtn};
		hFeed = {hFeed[1:0], feedBtn};
		eCnt = eCnt + 1;
		hCnt = hCnt + 1;
		mETick = (eCnt == `ENERGY_PERIOD);
		mHTick = (hCnt == `HUNGER_PERIOD);
		if (mETick) eCnt = 0;
		if (mHTick) hCnt = 0;
		mEnergy = nE;
		mHunger = nH;
		mMood = nM;
	endtask

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			{hSleep, hWake, hFeed} = '0;
			{mSleepEvt, mWakeEvt, mFeedEvt, mETick, mHTick} = '0;
			eCnt = 0;
			hCnt = 0;
			mEnergy = FULL;
			mHunger = FULL;
			mMood = IDLE;
		end else begin
			stepModel();
		end
	end

	task automatic compareMood(moodState_t got, moodState_t exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[FAIL] %0t: mood is %s, expected %s", $time, got.name(), exp.name());
		end
	endtask

	task automatic compareMeter(meterLevel_t got, meterLevel_t exp, string label);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, label, got, exp);
		end
	endtask

	// Outputs settle long before the falling edge
	always @(negedge clk) begin
		compareMood(mood, mMood);
		compareMeter(energy, mEnergy, "energy");
		compareMeter(hunger, mHunger, "hunger");
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic applyReset();
		rst = 1'b1;
		repeat (4) stepCycle();
		rst = 1'b0;
	endtask

	task automatic pressButton(buttonEvt_t which, int cyclesHeld);
		case (which)
			EVT_SLEEP: sleepBtn = 1'b1;
			EVT_WAKE: wakeBtn = 1'b1;
			EVT_FEED: feedBtn = 1'b1;
			default: ;
		endcase
		repeat (cyclesHeld) stepCycle();
		sleepBtn = 1'b0;
		wakeBtn = 1'b0;
		feedBtn = 1'b0;
	endtask

	task automatic endTest(string name);
		tests++;
		$display("%s: %0d errors", name, errors - testStartErrors);
		testStartErrors = errors;
	endtask

	initial begin
		rst = 1'b1;
		sleepBtn = 1'b0;
		wakeBtn = 1'b0;
		feedBtn = 1'b0;
		void'($urandom(SEED));

		applyReset(); // Idle decay down to DEATH, then meters hold
		while (mood != DEATH) stepCycle();
		deadEnergy = energy;
		deadHunger = hunger;
		repeat (2 * `ENERGY_PERIOD) stepCycle();
		compareMood(mood, DEATH);
		compareMeter(energy, deadEnergy, "frozen energy");
		compareMeter(hunger, deadHunger, "frozen hunger");
		endTest("idle decay");

		applyReset();
		while (hunger == FULL) stepCycle();
		pressButton(EVT_FEED, 1);
		repeat (6) stepCycle();
		pressButton(EVT_FEED, 1); // Already full, stays at the top
		repeat (6) stepCycle();
		compareMeter(hunger, FULL, "hunger fed at full");
		while (hunger > 3'd3) stepCycle();
		pressButton(EVT_FEED, 12); // Long hold counts once
		repeat (6) stepCycle();
		compareMeter(hunger, 3'd4, "hunger after long press");
		endTest("feeding");

		applyReset();
		while (energy == FULL) stepCycle();
		pressButton(EVT_SLEEP, 2);
		while (mood != SLEEP) stepCycle();
		while (mood == SLEEP) stepCycle();
		compareMeter(energy, FULL, "energy after sleep");
		endTest("sleep and recovery");

		applyReset();
		pressButton(EVT_SLEEP, 1); // Rested pet ignores it
		repeat (6) stepCycle();
		compareMood(mood, IDLE);
		while (energy == FULL) stepCycle();
		pressButton(EVT_SLEEP, 1);
		while (mood != SLEEP) stepCycle();
		repeat (5) stepCycle();
		pressButton(EVT_WAKE, 1);
		while (mood == SLEEP) stepCycle();
		endTest("wake");

		applyReset();
		for (int i = 0; i < ACTIONS; i++) begin
			if (i == ACTIONS / 2 || ($urandom % 64) == 0) applyReset();
			r = $urandom % 4;
			act = buttonEvt_t'(r[1:0]);
			len = 1 + int'($urandom % 2);
			gap = 3 + int'($urandom % 58);
			if (act != EVT_NONE) pressButton(act, len);
			repeat (gap) stepCycle();
		end
		endTest("random run");

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* petTop.sv */
// Top level of the virtual-pet core, wires buttons, tick generators, meters and mood FSM together
`timescale 1ns/100ps
`default_nettype none

`include "pet_defs.svh"

module petTop import petPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        sleepBtn, // Push buttons, raw levels
	input  logic        wakeBtn,
	input  logic        feedBtn,
	output moodState_t  mood,
	output meterLevel_t energy,
	output meterLevel_t hunger
);

	logic sleepEvt;   // Button pulses
	logic wakeEvt;
	logic feedEvt;
	logic energyTick; // Drain ticks
	logic hungerTick;

	// One synchronizer per button
	buttonSync uSleepSync (
		.clk (clk),
		.rst (rst),
		.btn (sleepBtn),
		.evt (sleepEvt)
	);

	buttonSync uWakeSync (
		.clk (clk),
		.rst (rst),
		.btn (wakeBtn),
		.evt (wakeEvt)
	);

	buttonSync uFeedSync (
		.clk (clk),
		.rst (rst),
		.btn (feedBtn),
		.evt (feedEvt)
	);

	tickGen #(.PERIOD(`ENERGY_PERIOD)) uEnergyTick (
		.clk  (clk),
		.rst  (rst),
		.tick (energyTick)
	);

	tickGen #(.PERIOD(`HUNGER_PERIOD)) uHungerTick (
		.clk  (clk),
		.rst  (rst),
		.tick (hungerTick)
	);

	vitalStats uVitals (
		.clk        (clk),
		.rst        (rst),
		.energyTick (energyTick),
		.hungerTick (hungerTick),
		.feedEvt    (feedEvt),
		.mood       (mood), // Sleep and death feed back into the meters
		.energy     (energy),
		.hunger     (hunger)
	);

	moodFsm uMood (
		.clk      (clk),
		.rst      (rst),
		.sleepEvt (sleepEvt),
		.wakeEvt  (wakeEvt),
		.energy   (energy),
		.hunger   (hunger),
		.mood     (mood)
	);

endmodule

`default_nettype wire

/* pet_defs.svh */
// Meter limits, tick periods and synchronizer depth for the pet core, included by RTL and bench
`ifndef PET_DEFS_SVH
`define PET_DEFS_SVH

// Meter scale runs from 0 up to METER_MAX
`define METER_MAX 5

// A meter at or below this level counts as low
`define METER_LOW 2

// Cycles between energy drain ticks (short values for simulation)
`define ENERGY_PERIOD 40

// Cycles between hunger drain ticks
`define HUNGER_PERIOD 25

// Flops in each button synchronizer chain, at least 2
`define SYNC_STAGES 2

`endif

/* run.sh */
#!/bin/sh
# Compile the pet testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module petTb -o petSim
./obj_dir/petSim | tee sim.log

if grep -q "Finished with errors" sim.log; then
	exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
	echo "Simulation stopped before the end of the run"
	exit 1
fi
exit 0

/* sim.f */
+incdir+.
petPkg.sv
buttonSync.sv
tickGen.sv
vitalStats.sv
moodFsm.sv
petTop.sv
petChecker.sv
petTb.sv

/* tickGen.sv */
// Free-running prescaler giving a one-cycle tick every PERIOD clocks, used for the meter drains
`timescale 1ns/100ps
`default_nettype none

module tickGen #(
	parameter int PERIOD = 16 // Clocks between ticks
) (
	input  logic clk,
	input  logic rst,
	output logic tick
);

	localparam int CW = (PERIOD > 1) ? $clog2(PERIOD) : 1;
	localparam logic [CW-1:0] LAST = CW'(PERIOD - 1); // Count value before wrap

	logic [CW-1:0] count;

	// Tick is registered, so it is high in the cycle after the wrap edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
			tick  <= 1'b0;
		end else if (count == LAST) begin
			count <= '0;
			tick  <= 1'b1; // Wrap
		end else begin
			count <= count + 1'b1;
			tick  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* vitalStats.sv */
// Energy and hunger meters of the pet, drained by ticks and raised by sleep or feeding
`timescale 1ns/100ps
`default_nettype none

`include "pet_defs.svh"

module vitalStats import petPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        energyTick, // Energy drain or recovery step
	input  logic        hungerTick, // Hunger drain step
	input  logic        feedEvt,    // One-cycle feed press
	input  moodState_t  mood,       // Current mood from the FSM
	output meterLevel_t energy,
	output meterLevel_t hunger
);

	localparam meterLevel_t FULL  = meterLevel_t'(`METER_MAX);
	localparam meterLevel_t EMPTY = meterLevel_t'(0);

	logic frozen;   // Pet is dead, meters hold
	logic sleeping;

	assign frozen   = (mood == DEATH);
	assign sleeping = (mood == SLEEP);

	// Energy meter
	// While asleep an energy tick adds one level, otherwise it drains one
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			energy <= FULL;
		end else if (!frozen && energyTick) begin
			if (sleeping && energy < FULL) begin
				energy <= energy + 1'b1; // Recovering
			end else if (energy > EMPTY) begin
				energy <= energy - 1'b1; // Drain
			end
		end
	end

	// Hunger meter
	// A feed press wins over a drain tick in the same cycle, even when hunger is full
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hunger <= FULL;
		end else if (!frozen) begin
			if (feedEvt) begin
				if (hunger < FULL) begin
					hunger <= hunger + 1'b1; // Fed
				end
			end else if (hungerTick && hunger > EMPTY) begin
				hunger <= hunger - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire
